/* all.f */
+incdir+.
lock_pkg.sv
lock_timer.sv
code_matcher.sv
lock_fsm.sv
door_lock_top.sv
tb_door_lock.sv

/* code_matcher.sv */
// three-stage search of the typed key sequence for any of the four
// stored codes, at any offset from 0 to MAX_SHIFT digits
module code_matcher (
  input  logic            clk,
  input  logic            rst,
  input  logic            check_start,
  input  lock_pkg::code_t key_digits,
  input  lock_pkg::code_t stored_code_0,
  input  lock_pkg::code_t stored_code_1,
  input  lock_pkg::code_t stored_code_2,
  input  lock_pkg::code_t stored_code_3,
  output logic            match_done,
  output logic            match_ok
);

  logic [lock_pkg::MATCH_LATENCY-1:0] valid_pipe;  // one bit per stage

  lock_pkg::code_t s1_keys;
  lock_pkg::code_t s1_code [4];
  lock_pkg::code_t mask_comb [4];
  lock_pkg::code_t s2_keys;
  lock_pkg::code_t s2_code [4];
  lock_pkg::code_t s2_mask [4];
  logic            hit;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_pipe <= '0;
    end
    else begin
      valid_pipe <= {valid_pipe[lock_pkg::MATCH_LATENCY-2:0], check_start};
    end
  end

  assign match_done = valid_pipe[lock_pkg::MATCH_LATENCY-1];

  ////////////////////
  // stage 1: capture

  always_ff @(posedge clk) begin
    if (check_start) begin
      s1_keys    <= key_digits;
      s1_code[0] <= stored_code_0;
      s1_code[1] <= stored_code_1;
      s1_code[2] <= stored_code_2;
      s1_code[3] <= stored_code_3;
    end
  end

  ////////////////////
  // stage 2: length and digit mask

  // length is the index of the first pad at or above MIN_CODE_LEN
  always_comb begin
    int len;
    for (int c = 0; c < $size(s1_code); c++) begin
      len = lock_pkg::MAX_CODE_LEN;  // no pad found, full length
      for (int d = lock_pkg::MAX_CODE_LEN; d >= lock_pkg::MIN_CODE_LEN; d--) begin
        if (s1_code[c][4*d +: 4] == lock_pkg::PAD_DIGIT) begin
          len = d;
        end
      end
      for (int d = 0; d < lock_pkg::CODE_DIGITS; d++) begin
        mask_comb[c][4*d +: 4] = (d < len) ? 4'hF : 4'h0;  // F = compared
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_pipe[0]) begin
      s2_keys <= s1_keys;
      s2_code <= s1_code;
      s2_mask <= mask_comb;
    end
  end

  ////////////////////
  // stage 3: shifted compare

  // pad digits come in from the top, so a code never matches past
  // the oldest typed key
  always_comb begin
    lock_pkg::code_t shifted;
    hit = 1'b0;
    for (int s = 0; s <= lock_pkg::MAX_SHIFT; s++) begin
      shifted = (s2_keys >> (4 * s)) | ~(lock_pkg::code_t'('1) >> (4 * s));
      for (int c = 0; c < $size(s2_code); c++) begin
        if (((shifted ^ s2_code[c]) & s2_mask[c]) == '0) begin
          hit = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      match_ok <= 1'b0;
    end
    else if (valid_pipe[lock_pkg::MATCH_LATENCY-2]) begin
      match_ok <= hit;  // lines up with match_done
    end
  end

endmodule

/* door_lock_top.sv */
module door_lock_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               door_sensor,    // high while open
  input  logic               inside_button,
  input  logic               privacy_button,
  input  lock_pkg::code_t    stored_code_0,
  input  lock_pkg::code_t    stored_code_1,
  input  lock_pkg::code_t    stored_code_2,
  input  lock_pkg::code_t    stored_code_3,
  input  lock_pkg::count_t   beep_time,
  input  lock_pkg::code_t    key_digits,
  input  logic               key_valid,
  output lock_pkg::display_t display_digits,
  output logic               keypad_en,
  output logic               display_en,
  output logic               lock,
  output logic               beep
);

  logic             check_start;
  logic             match_done;
  logic             match_ok;
  logic             main_clear;
  logic             main_run;
  lock_pkg::count_t main_limit;
  logic             main_expired;
  logic             close_clear;
  logic             close_run;
  logic             close_expired;

  lock_fsm lock_fsm_i (
    .clk            (clk),
    .rst            (rst),
    .door_sensor    (door_sensor),
    .inside_button  (inside_button),
    .privacy_button (privacy_button),
    .beep_time      (beep_time),
    .key_digits     (key_digits),
    .key_valid      (key_valid),
    .match_done     (match_done),
    .match_ok       (match_ok),
    .main_expired   (main_expired),
    .close_expired  (close_expired),
    .check_start    (check_start),
    .main_clear     (main_clear),
    .main_run       (main_run),
    .main_limit     (main_limit),
    .close_clear    (close_clear),
    .close_run      (close_run),
    .display_digits (display_digits),
    .keypad_en      (keypad_en),
    .display_en     (display_en),
    .lock           (lock),
    .beep           (beep)
  );

  code_matcher code_matcher_i (
    .clk           (clk),
    .rst           (rst),
    .check_start   (check_start),
    .key_digits    (key_digits),
    .stored_code_0 (stored_code_0),
    .stored_code_1 (stored_code_1),
    .stored_code_2 (stored_code_2),
    .stored_code_3 (stored_code_3),
    .match_done    (match_done),
    .match_ok      (match_ok)
  );

  // per-state delays, limit picked by the FSM
  lock_timer main_timer_i (
    .clk     (clk),
    .rst     (rst),
    .clear   (main_clear),
    .run     (main_run),
    .limit   (main_limit),
    .expired (main_expired)
  );

  lock_timer close_timer_i (
    .clk     (clk),
    .rst     (rst),
    .clear   (close_clear),
    .run     (close_run),
    .limit   (lock_pkg::AUTO_LOCK_CYCLES),
    .expired (close_expired)
  );

endmodule

/* lock_fsm.sv */
// door state machine, wrong-attempt counter and output decode
module lock_fsm (
  input  logic               clk,
  input  logic               rst,
  input  logic               door_sensor,
  input  logic               inside_button,
  input  logic               privacy_button,
  input  lock_pkg::count_t   beep_time,
  input  lock_pkg::code_t    key_digits,
  input  logic               key_valid,
  input  logic               match_done,
  input  logic               match_ok,
  input  logic               main_expired,
  input  logic               close_expired,
  output logic               check_start,
  output logic               main_clear,
  output logic               main_run,
  output lock_pkg::count_t   main_limit,
  output logic               close_clear,
  output logic               close_run,
  output lock_pkg::display_t display_digits,
  output logic               keypad_en,
  output logic               display_en,
  output logic               lock,
  output logic               beep
);

  typedef enum logic [3:0] {
    st_reset,
    st_locked,
    st_closed,             // closed and unlocked
    st_open,
    st_open_beep,
    st_cancel_beep,
    st_checking,
    st_wrong,
    st_lockout,
    st_privacy,
    st_deb_privacy,
    st_deb_exit_privacy,
    st_deb_lock,
    st_deb_unlock
  } state_t;

  state_t state;
  state_t state_next;

  logic [$clog2(lock_pkg::MAX_ATTEMPTS + 1)-1:0] attempts;

  logic             inside_q;
  logic             privacy_q;
  logic             inside_press;
  logic             privacy_press;
  lock_pkg::digit_t last_key;
  logic             cancel_key;
  logic             confirm_key;
  logic             wrong_result;
  logic             last_attempt;

  ////////////////////
  // key and button decode

  assign last_key    = key_digits[3:0];
  assign cancel_key  = key_valid && (last_key == lock_pkg::KEY_CANCEL);
  assign confirm_key = key_valid && (last_key != lock_pkg::KEY_CANCEL)
                       && (last_key != lock_pkg::KEY_EXIT);

  // press edges, so a held button acts only once
  assign inside_press  = inside_button && !inside_q;
  assign privacy_press = privacy_button && !privacy_q;

  assign wrong_result = match_done && !match_ok;
  assign last_attempt = (attempts >= lock_pkg::MAX_ATTEMPTS - 1);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      inside_q  <= 1'b0;
      privacy_q <= 1'b0;
    end
    else begin
      inside_q  <= inside_button;
      privacy_q <= privacy_button;
    end
  end

  ////////////////////
  // next state

  always_comb begin
    state_next = state;
    case (state)
      st_reset: begin
        if (!door_sensor) state_next = st_locked;
      end
      st_locked: begin
        if (cancel_key) state_next = st_cancel_beep;
        else if (privacy_press) state_next = st_deb_privacy;
        else if (inside_press) state_next = st_deb_unlock;
        else if (confirm_key) state_next = st_checking;
      end
      st_closed: begin
        if (inside_press) state_next = st_deb_lock;
        else if (door_sensor) state_next = st_open;
        else if (close_expired) state_next = st_locked;  // auto-lock
      end
      st_open: begin
        if (!door_sensor) state_next = st_closed;
        else if (main_expired) state_next = st_open_beep;
      end
      st_open_beep: begin
        if (!door_sensor) state_next = st_closed;
      end
      st_cancel_beep: begin
        if (main_expired) state_next = st_locked;
      end
      st_checking: begin
        if (match_done && match_ok) state_next = st_closed;
        else if (wrong_result && last_attempt) state_next = st_lockout;
        else if (wrong_result) state_next = st_wrong;
      end
      st_wrong: begin
        if (main_expired) state_next = st_locked;
      end
      st_lockout: begin
        if (main_expired) state_next = st_locked;
      end
      st_privacy: begin
        if (inside_press) state_next = st_deb_exit_privacy;
      end
      // debounce: expiry first, then a release falls back
      st_deb_privacy: begin
        if (main_expired) state_next = st_privacy;
        else if (!privacy_button) state_next = st_locked;
      end
      st_deb_exit_privacy: begin
        if (main_expired) state_next = st_closed;
        else if (!inside_button) state_next = st_privacy;
      end
      st_deb_lock: begin
        if (main_expired) state_next = st_locked;
        else if (!inside_button) state_next = st_closed;
      end
      st_deb_unlock: begin
        if (main_expired) state_next = st_closed;
        else if (!inside_button) state_next = st_locked;
      end
      default: state_next = st_reset;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= st_reset;
    end
    else begin
      state <= state_next;
    end
  end

  // cleared only when a lockout ends
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      attempts <= '0;
    end
    else if ((state == st_lockout) && (state_next == st_locked)) begin
      attempts <= '0;
    end
    else if ((state == st_checking) && wrong_result) begin
      attempts <= attempts + 1'b1;
    end
  end

  // matcher starts in the same cycle as the confirm key
  assign check_start = (state == st_locked) && (state_next == st_checking);

  ////////////////////
  // timer control

  assign main_clear  = (state_next != state);  // restart on every state change
  assign close_clear = (state != st_closed);
  assign close_run   = (state == st_closed);

  always_comb begin
    main_run   = 1'b1;
    main_limit = '1;
    case (state)
      st_open:        main_limit = beep_time;
      st_cancel_beep: main_limit = lock_pkg::CANCEL_BEEP_CYCLES;
      st_wrong:       main_limit = lock_pkg::WRONG_HOLD_CYCLES;
      st_lockout:     main_limit = lock_pkg::LOCKOUT_CYCLES;
      st_deb_privacy, st_deb_exit_privacy, st_deb_lock, st_deb_unlock: begin
        main_limit = lock_pkg::DEBOUNCE_CYCLES;
      end
      default:        main_run = 1'b0;  // untimed state
    endcase
  end

  ////////////////////
  // outputs

  always_comb begin
    display_digits = {lock_pkg::DISPLAY_DIGITS{lock_pkg::DIGIT_BLANK}};
    keypad_en      = 1'b0;
    display_en     = 1'b1;
    lock           = 1'b1;
    beep           = 1'b0;
    case (state)
      st_reset, st_closed, st_open, st_deb_lock: lock = 1'b0;
      st_open_beep: begin
        lock = 1'b0;
        beep = 1'b1;
      end
      st_locked:      keypad_en = 1'b1;
      st_cancel_beep: beep = 1'b1;
      st_wrong: begin
        // one mark per wrong code, from the right
        for (int i = 0; i < lock_pkg::DISPLAY_DIGITS; i++) begin
          if (i < attempts) display_digits[4*i +: 4] = lock_pkg::DIGIT_MARK;
        end
      end
      st_lockout: begin
        for (int i = 0; i < lock_pkg::DISPLAY_DIGITS; i++) begin
          if (i < lock_pkg::MAX_ATTEMPTS) display_digits[4*i +: 4] = lock_pkg::DIGIT_MARK;
        end
      end
      st_privacy, st_deb_exit_privacy: display_en = 1'b0;  // do not disturb
      default: ;
    endcase
  end

endmodule

/* lock_pkg.sv */
package lock_pkg;

  ////////////////////
  // sizes

  localparam int CODE_DIGITS    = 20;  // digits held in a key sequence
  localparam int DISPLAY_DIGITS = 6;
  localparam int MAX_SHIFT      = 16;  // highest offset tried by the matcher
  localparam int MIN_CODE_LEN   = 4;
  localparam int MAX_CODE_LEN   = 12;
  localparam int MAX_ATTEMPTS   = 5;   // wrong codes before lockout
  localparam int MATCH_LATENCY  = 3;   // check_start to match_done

  ////////////////////
  // types

  typedef logic [3:0] digit_t;

  // digit 0 is the most recent key
  // a stored code is padded with hex F above its length
  typedef logic [CODE_DIGITS*4-1:0] code_t;

  typedef logic [DISPLAY_DIGITS*4-1:0] display_t;
  typedef logic [15:0] count_t;

  ////////////////////
  // key and display codes

  localparam digit_t KEY_CANCEL  = 4'hE;
  localparam digit_t KEY_EXIT    = 4'hB;  // never a confirm
  localparam digit_t PAD_DIGIT   = 4'hF;
  localparam digit_t DIGIT_BLANK = 4'hB;
  localparam digit_t DIGIT_MARK  = 4'hA;

  ////////////////////
  // timing, in clock cycles

  localparam count_t AUTO_LOCK_CYCLES   = 16'd5000;
  localparam count_t DEBOUNCE_CYCLES    = 16'd100;
  localparam count_t CANCEL_BEEP_CYCLES = 16'd50;
  localparam count_t WRONG_HOLD_CYCLES  = 16'd1000;
  localparam count_t LOCKOUT_CYCLES     = 16'd30000;

endpackage

/* lock_timer.sv */
// up-counter with a sticky limit flag
// used for the per-state delays and for the auto-lock delay
module lock_timer (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,
  input  logic             run,
  input  lock_pkg::count_t limit,
  output logic             expired
);

  lock_pkg::count_t count;

  // compare as >= so a limit lowered mid-count still fires
  assign expired = (count >= limit);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count <= '0;
    end
    else if (clear) begin
      count <= '0;  // clear wins over run
    end
    else if (run && !expired) begin
      count <= count + 1'b1;  // stops at the limit, no wrap
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile and run the door lock testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_door_lock -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_door_lock)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

/* tb_door_lock_checks.svh */
`ifndef TB_DOOR_LOCK_CHECKS_SVH
`define TB_DOOR_LOCK_CHECKS_SVH

int          errors = 0;
int          tests_done = 0;
logic [31:0] rand_state = 32'h7f03;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] next_random();
  rand_state = xorshift32(rand_state);
  return rand_state;
endfunction

function automatic bit within_tolerance(input int cycles, input int target);
  return (cycles >= target - 3) && (cycles <= target + 3);  // +-3 cycles
endfunction

task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
  errors++;
  $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
endtask

////////////////////
// reset outputs

reset_lock: assert property (@(posedge clk) rst |-> !lock)
  else value_error("lock", 32'd0, 32'(lock));
reset_beep: assert property (@(posedge clk) rst |-> !beep)
  else value_error("beep", 32'd0, 32'(beep));
reset_display_en: assert property (@(posedge clk) rst |-> display_en)
  else value_error("display_en", 32'd1, 32'(display_en));
reset_display: assert property (@(posedge clk) rst |-> display_digits == blank_display)
  else value_error("display_digits", 32'(blank_display), 32'(display_digits));

////////////////////
// running checks

// confirm to unlock is 4 cycles
open_hold: assert property (@(posedge clk) disable iff (rst)
  (expect_open && key_valid) |-> ##3 lock)
  else value_error("lock", 32'd1, 32'(lock));
open_latency: assert property (@(posedge clk) disable iff (rst)
  (expect_open && key_valid) |-> ##4 !lock)
  else value_error("lock", 32'd0, 32'(lock));
lock_hold: assert property (@(posedge clk) disable iff (rst) watch_lock |-> lock)
  else value_error("lock", 32'd1, 32'(lock));
display_hold: assert property (@(posedge clk) disable iff (rst)
  watch_display |-> display_digits == exp_display)
  else value_error("display_digits", 32'(exp_display), 32'(display_digits));

`endif

/* tb_door_lock.sv */
module tb_door_lock;
  timeunit 1ns;
  timeprecision 100ps;

  localparam lock_pkg::display_t blank_display = {6{lock_pkg::DIGIT_BLANK}};

  logic               clk = 1'b0;
  logic               rst = 1'b0;
  logic               door_sensor;
  logic               inside_button;
  logic               privacy_button;
  lock_pkg::code_t    stored [4];
  lock_pkg::count_t   beep_time;
  lock_pkg::code_t    key_digits;
  logic               key_valid;
  lock_pkg::display_t display_digits;
  logic               keypad_en;
  logic               display_en;
  logic               lock;
  logic               beep;

  // expectations set by the stimulus
  logic               expect_open = 1'b0;
  logic               watch_lock = 1'b0;
  logic               watch_display = 1'b0;
  lock_pkg::display_t exp_display = '0;

  `include "tb_door_lock_checks.svh"

  always #10 clk = ~clk;  // 20 ns period

  door_lock_top door_lock_top_i (
    .clk            (clk),
    .rst            (rst),
    .door_sensor    (door_sensor),
    .inside_button  (inside_button),
    .privacy_button (privacy_button),
    .stored_code_0  (stored[0]),
    .stored_code_1  (stored[1]),
    .stored_code_2  (stored[2]),
    .stored_code_3  (stored[3]),
    .beep_time      (beep_time),
    .key_digits     (key_digits),
    .key_valid      (key_valid),
    .display_digits (display_digits),
    .keypad_en      (keypad_en),
    .display_en     (display_en),
    .lock           (lock),
    .beep           (beep)
  );

  // n marks from the right with blanks above
  function automatic lock_pkg::display_t marks(input int n);
    lock_pkg::display_t d;
    for (int i = 0; i < 6; i++) begin
      d[4*i +: 4] = (i < n) ? lock_pkg::DIGIT_MARK : lock_pkg::DIGIT_BLANK;
    end
    return d;
  endfunction

  function automatic logic probe(input string name);
    case (name)
      "lock":      return lock;
      "beep":      return beep;
      "keypad_en": return keypad_en;
      default:     return display_en;
    endcase
  endfunction

  task automatic wait_for(input string name, input logic value, input int limit,
                          output int cycles);
    cycles = 0;
    while (probe(name) != value && cycles <= limit) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles > limit) begin
      $display("timeout at %0t: %s did not reach %0d", $time, name, value);
      $display("Regression failed");
      $finish;
    end
  endtask

  task automatic press_key(input lock_pkg::code_t seq, input logic correct);
    @(negedge clk);
    key_digits  = seq;
    key_valid   = 1'b1;
    expect_open = correct;
    @(negedge clk);
    key_valid   = 1'b0;
    expect_open = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("test %0d %s done, errors so far %0d", tests_done, name, errors);
  endtask

  initial begin
    int              len;
    int              slot;
    int              pos;
    int              cycles;
    lock_pkg::code_t good_code;
    lock_pkg::code_t seq;
    door_sensor    = 1'b0;
    inside_button  = 1'b0;
    privacy_button = 1'b0;
    beep_time      = 16'd200;
    key_digits     = '0;
    key_valid      = 1'b0;
    for (int i = 0; i < 4; i++) stored[i] = {{16{4'hF}}, 16'hCCCC};  // never typed
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    ////////////////////
    // reset and correct code
    wait_for("lock", 1'b1, 10, cycles);
    assert (keypad_en) else value_error("keypad_en", 32'd1, 32'(keypad_en));
    finish_test("reset");

    len  = 4 + int'(next_random() % 9);
    slot = int'(next_random() % 4);
    pos  = int'(next_random() % 17);
    if (pos + len > lock_pkg::CODE_DIGITS) pos = lock_pkg::CODE_DIGITS - len;
    good_code = '1;
    for (int i = 0; i < lock_pkg::CODE_DIGITS; i++) seq[4*i +: 4] = 4'(next_random() % 10);
    for (int i = 0; i < len; i++) begin
      good_code[4*i +: 4] = 4'(next_random() % 10);
      seq[4*(pos+i) +: 4] = good_code[4*i +: 4];  // code hidden in filler
    end
    stored[slot] = good_code;
    press_key(seq, 1'b1);
    wait_for("lock", 1'b0, 10, cycles);
    wait_for("lock", 1'b1, lock_pkg::AUTO_LOCK_CYCLES + 20, cycles);
    assert (within_tolerance(cycles, lock_pkg::AUTO_LOCK_CYCLES))
      else value_error("auto-lock cycles", lock_pkg::AUTO_LOCK_CYCLES, cycles);
    finish_test("correct code");

    // digit D appears in no stored code
    for (int n = 1; n <= lock_pkg::MAX_ATTEMPTS; n++) begin
      press_key({lock_pkg::CODE_DIGITS{4'hD}}, 1'b0);
      repeat (3) @(negedge clk);
      exp_display = (n < lock_pkg::MAX_ATTEMPTS) ? marks(n) : marks(5);
      watch_display = 1'b1;
      watch_lock    = 1'b1;
      assert (!keypad_en) else value_error("keypad_en", 32'd0, 32'(keypad_en));
      wait_for("keypad_en", 1'b1, lock_pkg::LOCKOUT_CYCLES + 20, cycles);
      watch_display = 1'b0;
      watch_lock    = 1'b0;
      if (n == lock_pkg::MAX_ATTEMPTS) begin
        assert (within_tolerance(cycles, lock_pkg::LOCKOUT_CYCLES))
          else value_error("lockout cycles", lock_pkg::LOCKOUT_CYCLES, cycles);
      end
      else begin
        assert (within_tolerance(cycles, lock_pkg::WRONG_HOLD_CYCLES))
          else value_error("wrong hold cycles", lock_pkg::WRONG_HOLD_CYCLES, cycles);
      end
    end
    assert (display_digits == blank_display)
      else value_error("display_digits", 32'(blank_display), 32'(display_digits));
    finish_test("wrong codes");

    press_key(lock_pkg::code_t'(lock_pkg::KEY_CANCEL), 1'b0);
    wait_for("beep", 1'b1, 10, cycles);
    wait_for("beep", 1'b0, lock_pkg::CANCEL_BEEP_CYCLES + 20, cycles);
    assert (within_tolerance(cycles, lock_pkg::CANCEL_BEEP_CYCLES))
      else value_error("cancel beep cycles", lock_pkg::CANCEL_BEEP_CYCLES, cycles);
    assert (keypad_en) else value_error("keypad_en", 32'd1, 32'(keypad_en));
    finish_test("cancel key");

    ////////////////////
    // buttons and door
    watch_lock = 1'b1;
    inside_button = 1'b1;  // bounce shorter than the debounce time
    repeat (50) @(negedge clk);
    inside_button = 1'b0;
    repeat (10) @(negedge clk);
    watch_lock = 1'b0;
    inside_button = 1'b1;
    wait_for("lock", 1'b0, lock_pkg::DEBOUNCE_CYCLES + 20, cycles);
    assert (within_tolerance(cycles, lock_pkg::DEBOUNCE_CYCLES))
      else value_error("debounce cycles", lock_pkg::DEBOUNCE_CYCLES, cycles);
    inside_button = 1'b0;
    door_sensor   = 1'b1;
    wait_for("beep", 1'b1, int'(beep_time) + 20, cycles);
    assert (within_tolerance(cycles, int'(beep_time)))
      else value_error("open beep cycles", 32'(beep_time), cycles);
    repeat (100) begin
      @(negedge clk);
      assert (beep) else value_error("beep", 32'd1, 32'(beep));
    end
    door_sensor = 1'b0;
    wait_for("beep", 1'b0, 5, cycles);
    inside_button = 1'b1;
    wait_for("lock", 1'b1, lock_pkg::DEBOUNCE_CYCLES + 20, cycles);
    inside_button = 1'b0;
    finish_test("inside button and door");

    privacy_button = 1'b1;
    wait_for("display_en", 1'b0, lock_pkg::DEBOUNCE_CYCLES + 20, cycles);
    privacy_button = 1'b0;
    assert (!keypad_en) else value_error("keypad_en", 32'd0, 32'(keypad_en));
    watch_lock = 1'b1;
    press_key(seq, 1'b0);  // right code while the keypad is off
    repeat (10) @(negedge clk);
    watch_lock    = 1'b0;
    inside_button = 1'b1;
    wait_for("lock", 1'b0, lock_pkg::DEBOUNCE_CYCLES + 20, cycles);
    inside_button = 1'b0;
    assert (display_en) else value_error("display_en", 32'd1, 32'(display_en));
    finish_test("privacy");

    $display("tests %0d, errors %0d", tests_done, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end
    else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
